// File: design/arith_pkg.sv
package arith_pkg;

  // Operand and result width
  localparam int WIDTH = 16;

  // Width of the opcode field
  localparam int OP_WIDTH = 2;

  // Multiplier splits the right operand at this bit for its partial products
  localparam int MUL_SPLIT = WIDTH / 2;

  // Cycles from the accepting edge to the edge that raises done
  localparam int MUL_LATENCY = 2;

  // One load edge, WIDTH iteration edges, one finish edge minus the load
  localparam int DIV_LATENCY = WIDTH + 1;

  // Wide enough to count from zero up to WIDTH iterations
  localparam int DIV_COUNT_WIDTH = $clog2(WIDTH + 1);

  // Operation select
  // The fourth encoding is reserved and never accepted
  typedef enum logic [OP_WIDTH-1:0] {
    OP_MUL  = 2'd0,
    OP_DIVU = 2'd1,
    OP_DIVS = 2'd2
  } op_t;

endpackage

// File: design/op_capture.sv
module op_capture import arith_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             go,
  input  op_t              op,
  input  logic [WIDTH-1:0] left,
  input  logic [WIDTH-1:0] right,
  input  logic             div_running,
  output logic             busy,
  output logic             mul_go,
  output logic [WIDTH-1:0] mul_left,
  output logic [WIDTH-1:0] mul_right,
  output logic             div_go,
  output logic [WIDTH-1:0] div_left,
  output logic [WIDTH-1:0] div_right,
  output logic             div_signed,
  output logic             left_neg,
  output logic             right_neg,
  output logic [WIDTH-1:0] right_mag
);

  logic             op_valid;
  logic             is_div;
  logic             is_signed;
  logic             accept;
  logic [WIDTH-1:0] left_abs;
  logic [WIDTH-1:0] right_abs;

  // Opcode decode
  always_comb begin
    op_valid  = 1'b0;
    is_div    = 1'b0;
    is_signed = 1'b0;
    case (op)
      OP_MUL: begin
        op_valid = 1'b1;
      end
      OP_DIVU: begin
        op_valid = 1'b1;
        is_div   = 1'b1;
      end
      OP_DIVS: begin
        op_valid  = 1'b1;
        is_div    = 1'b1;
        is_signed = 1'b1;
      end
      default: begin
        op_valid = 1'b0;
      end
    endcase
  end

  // The divider raises running on the accepting edge itself,
  // so its flag already covers the whole divide
  assign busy = div_running;

  assign accept = go && op_valid && !busy;
  assign mul_go = accept && !is_div;
  assign div_go = accept && is_div;

  // Magnitudes, 0x8000 maps onto itself and is read as unsigned
  assign left_abs  = left[WIDTH-1] ? -left : left;
  assign right_abs = right[WIDTH-1] ? -right : right;

  assign mul_left  = left;
  assign mul_right = right;
  assign div_left  = is_signed ? left_abs : left;
  assign div_right = is_signed ? right_abs : right;

  // Sign state for the output correction, kept until the next divide
  always_ff @(posedge clk) begin
    if (reset) begin
      div_signed <= 1'b0;
      left_neg   <= 1'b0;
      right_neg  <= 1'b0;
    end else if (div_go) begin
      div_signed <= is_signed;
      left_neg   <= left[WIDTH-1];
      right_neg  <= right[WIDTH-1];
    end
  end

  always_ff @(posedge clk) begin
    if (div_go) begin
      right_mag <= right_abs;
    end
  end

endmodule

// File: design/mult_pipe.sv
module mult_pipe import arith_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             mul_go,
  input  logic [WIDTH-1:0] mul_left,
  input  logic [WIDTH-1:0] mul_right,
  output logic             mul_done,
  output logic [WIDTH-1:0] mul_result
);

  // Stage one, registered operands
  logic                       op_valid;
  logic [WIDTH-1:0]           op_a;
  logic [WIDTH-1:0]           op_b;

  // Partial products of the low result half
  logic                       pp_valid;
  logic [WIDTH-1:0]           pp_lo;
  logic [WIDTH-MUL_SPLIT-1:0] pp_hi;

  // Valid bits walk alongside the data, one product may enter each cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      op_valid <= 1'b0;
      pp_valid <= 1'b0;
      mul_done <= 1'b0;
    end else begin
      op_valid <= mul_go;
      pp_valid <= op_valid;
      mul_done <= pp_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (mul_go) begin
      op_a <= mul_left;
      op_b <= mul_right;
    end
  end

  // Only the low WIDTH bits are kept, so the upper partial product
  // needs just the bits that land below WIDTH
  always_ff @(posedge clk) begin
    if (op_valid) begin
      pp_lo <= op_a * op_b[MUL_SPLIT-1:0];
      pp_hi <= op_a[WIDTH-MUL_SPLIT-1:0] * op_b[WIDTH-1:MUL_SPLIT];
    end
  end

  // Stage two, product held until the next one arrives
  always_ff @(posedge clk) begin
    if (pp_valid) begin
      mul_result <= pp_lo + {pp_hi, {MUL_SPLIT{1'b0}}};
    end
  end

endmodule

// File: design/div_core.sv
module div_core import arith_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             div_go,
  input  logic [WIDTH-1:0] div_left,
  input  logic [WIDTH-1:0] div_right,
  output logic             div_running,
  output logic             div_done,
  output logic [WIDTH-1:0] div_quotient,
  output logic [WIDTH-1:0] div_remainder
);

  logic [WIDTH-1:0]           dividend;
  logic [2*WIDTH-2:0]         divisor;
  logic [WIDTH-1:0]           quotient;
  logic [WIDTH-1:0]           quotient_msk;
  logic [DIV_COUNT_WIDTH-1:0] iter_count;
  logic                       step;
  logic                       fits;
  logic                       finished;

  // One quotient bit per running cycle until all WIDTH bits are resolved
  assign step = div_running && (iter_count != DIV_COUNT_WIDTH'(WIDTH));

  // Mask has shifted out its last bit, the loop is over
  assign finished = div_running && (quotient_msk == '0);

  assign fits = divisor <= {{(WIDTH-1){1'b0}}, dividend};

  always_ff @(posedge clk) begin
    if (reset) begin
      div_running <= 1'b0;
      div_done    <= 1'b0;
      iter_count  <= '0;
    end else begin
      div_done <= finished;
      if (div_go) begin
        div_running <= 1'b1;
        iter_count  <= '0;
      end else if (finished) begin
        div_running <= 1'b0;
      end else if (step) begin
        iter_count <= iter_count + 1'b1;
      end
    end
  end

  // Restoring loop
  // A zero divisor always fits, giving all ones and an untouched dividend
  always_ff @(posedge clk) begin
    if (div_go) begin
      dividend     <= div_left;
      divisor      <= {{(WIDTH-1){1'b0}}, div_right} << (WIDTH - 1);
      quotient_msk <= {1'b1, {(WIDTH-1){1'b0}}};
      quotient     <= '0;
    end else if (step) begin
      if (fits) begin
        // Upper divisor bits are zero whenever it fits
        dividend <= dividend - divisor[WIDTH-1:0];
        quotient <= quotient | quotient_msk;
      end
      divisor      <= divisor >> 1;
      quotient_msk <= quotient_msk >> 1;
    end
  end

  // Results stay put until the next divide finishes
  always_ff @(posedge clk) begin
    if (finished) begin
      div_quotient  <= quotient;
      div_remainder <= dividend;
    end
  end

endmodule

// File: design/result_format.sv
module result_format import arith_pkg::*; (
  input  logic             mul_done,
  input  logic [WIDTH-1:0] mul_result,
  input  logic             div_done,
  input  logic [WIDTH-1:0] div_quotient,
  input  logic [WIDTH-1:0] div_remainder,
  input  logic             div_signed,
  input  logic             left_neg,
  input  logic             right_neg,
  input  logic [WIDTH-1:0] right_mag,
  output logic             done,
  output logic [WIDTH-1:0] result,
  output logic [WIDTH-1:0] remainder
);

  logic             signs_differ;
  logic [WIDTH-1:0] quot_signed;
  logic [WIDTH-1:0] rem_adjusted;
  logic [WIDTH-1:0] rem_signed;

  // Busy keeps the two units from finishing together
  assign done = mul_done | div_done;

  assign signs_differ = left_neg ^ right_neg;

  // Quotient truncates toward zero
  assign quot_signed = signs_differ ? -div_quotient : div_quotient;

  // Fold the magnitude remainder into the divisor's range,
  // then give it the divisor's sign
  assign rem_adjusted = (signs_differ && (div_remainder != '0)) ?
                        right_mag - div_remainder : div_remainder;
  assign rem_signed   = right_neg ? -rem_adjusted : rem_adjusted;

  always_comb begin
    if (mul_done) begin
      result    = mul_result;
      remainder = '0;
    end else if (div_signed) begin
      result    = quot_signed;
      remainder = rem_signed;
    end else begin
      result    = div_quotient;
      remainder = div_remainder;
    end
  end

endmodule

// File: design/arith_unit.sv
module arith_unit import arith_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             go,
  input  op_t              op,
  input  logic [WIDTH-1:0] left,
  input  logic [WIDTH-1:0] right,
  output logic             done,
  output logic             busy,
  output logic [WIDTH-1:0] result,
  output logic [WIDTH-1:0] remainder
);

  // Multiplier path
  logic             mul_go;
  logic [WIDTH-1:0] mul_left;
  logic [WIDTH-1:0] mul_right;
  logic             mul_done;
  logic [WIDTH-1:0] mul_result;

  // Divider path
  logic             div_go;
  logic [WIDTH-1:0] div_left;
  logic [WIDTH-1:0] div_right;
  logic             div_running;
  logic             div_done;
  logic [WIDTH-1:0] div_quotient;
  logic [WIDTH-1:0] div_remainder;

  // Sign state for the signed divide
  logic             div_signed;
  logic             left_neg;
  logic             right_neg;
  logic [WIDTH-1:0] right_mag;

  op_capture u_capture (
    .clk         (clk),
    .reset       (reset),
    .go          (go),
    .op          (op),
    .left        (left),
    .right       (right),
    .div_running (div_running),
    .busy        (busy),
    .mul_go      (mul_go),
    .mul_left    (mul_left),
    .mul_right   (mul_right),
    .div_go      (div_go),
    .div_left    (div_left),
    .div_right   (div_right),
    .div_signed  (div_signed),
    .left_neg    (left_neg),
    .right_neg   (right_neg),
    .right_mag   (right_mag)
  );

  mult_pipe u_mult (
    .clk        (clk),
    .reset      (reset),
    .mul_go     (mul_go),
    .mul_left   (mul_left),
    .mul_right  (mul_right),
    .mul_done   (mul_done),
    .mul_result (mul_result)
  );

  div_core u_div (
    .clk           (clk),
    .reset         (reset),
    .div_go        (div_go),
    .div_left      (div_left),
    .div_right     (div_right),
    .div_running   (div_running),
    .div_done      (div_done),
    .div_quotient  (div_quotient),
    .div_remainder (div_remainder)
  );

  result_format u_format (
    .mul_done      (mul_done),
    .mul_result    (mul_result),
    .div_done      (div_done),
    .div_quotient  (div_quotient),
    .div_remainder (div_remainder),
    .div_signed    (div_signed),
    .left_neg      (left_neg),
    .right_neg     (right_neg),
    .right_mag     (right_mag),
    .done          (done),
    .result        (result),
    .remainder     (remainder)
  );

endmodule

// File: tb/arith_unit_assert.sv
module arith_unit_assert import arith_pkg::*; (
  input logic                clk,
  input logic                reset,
  input logic                go,
  input logic [OP_WIDTH-1:0] op,
  input logic                busy,
  input logic                done
);

  timeunit 1ns;
  timeprecision 100ps;

  logic mul_accept;
  logic div_accept;
  int   fail_count = 0;

  assign mul_accept = go && !busy && (op == OP_MUL);
  assign div_accept = go && !busy && ((op == OP_DIVU) || (op == OP_DIVS));

  // Two dones in a row only from multiplies accepted on consecutive edges
  done_spacing: assert property (@(posedge clk) disable iff (reset)
    (done && $past(done)) |->
      ($past(mul_accept, MUL_LATENCY + 1) && $past(mul_accept, MUL_LATENCY + 2)))
  else begin
    fail_count = fail_count + 1;
    $error("done high on consecutive cycles without back-to-back multiplies");
  end

  // Product is out after a fixed latency
  mul_timing: assert property (@(posedge clk) disable iff (reset)
    mul_accept |=> ##MUL_LATENCY done)
  else begin
    fail_count = fail_count + 1;
    $error("multiply did not raise done after the pipeline latency");
  end

  // busy covers the whole divide and drops in its done cycle
  busy_window: assert property (@(posedge clk) disable iff (reset)
    div_accept |=> busy [*DIV_LATENCY] ##1 !busy)
  else begin
    fail_count = fail_count + 1;
    $error("busy window of a divide has the wrong length");
  end

endmodule

bind arith_unit arith_unit_assert u_assert (
  .clk   (clk),
  .reset (reset),
  .go    (go),
  .op    (op),
  .busy  (busy),
  .done  (done)
);

// File: tb/arith_unit_tb.sv
module arith_unit_tb import arith_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int SEED         = 34602;

  // Operations issued per test group
  localparam int NUM_MUL      = 20;
  localparam int NUM_DIVU     = 20;
  localparam int NUM_DIVS     = 16;
  localparam int NUM_EXACT    = 8;
  localparam int NUM_DIRECTED = 14;
  localparam int NUM_OPS      = NUM_MUL + NUM_DIVU + NUM_DIVS + NUM_EXACT + NUM_DIRECTED;

  localparam int WATCHDOG_CYCLES = NUM_OPS * (DIV_LATENCY + 4) + RESET_CYCLES;

  logic             clk;
  logic             reset;
  logic             go;
  op_t              op;
  logic [WIDTH-1:0] left;
  logic [WIDTH-1:0] right;
  logic             done;
  logic             busy;
  logic [WIDTH-1:0] result;
  logic [WIDTH-1:0] remainder;

  // Number of the last rising edge
  int cycle;

  // Busy window of the divide in progress in edge numbers
  int div_start;
  int busy_to;

  logic [31:0] rng_state;

  // Expected outputs and their done edge in issue order
  logic [WIDTH-1:0] exp_result_q[$];
  logic [WIDTH-1:0] exp_rem_q[$];
  int               exp_cycle_q[$];

  arith_unit DUT (
    .clk       (clk),
    .reset     (reset),
    .go        (go),
    .op        (op),
    .left      (left),
    .right     (right),
    .done      (done),
    .busy      (busy),
    .result    (result),
    .remainder (remainder)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Expected {result, remainder} for one operation
  function automatic logic [2*WIDTH-1:0] ref_result(input op_t code,
                                                    input logic [WIDTH-1:0] l,
                                                    input logic [WIDTH-1:0] r);
    logic [2*WIDTH-1:0] prod;
    logic [WIDTH-1:0]   res;
    logic [WIDTH-1:0]   rem;
    int                 ll;
    int                 rr;
    int                 q;
    int                 m;
    res = '0;
    rem = '0;
    case (code)
      OP_MUL: begin
        prod = l * r;
        res  = prod[WIDTH-1:0];
      end
      OP_DIVU: begin
        if (r == '0) begin
          res = '1;
          rem = l;
        end else begin
          res = l / r;
          rem = l % r;
        end
      end
      OP_DIVS: begin
        ll = int'($signed(l));
        rr = int'($signed(r));
        q  = ll / rr;
        m  = ll % rr;
        // Floored modulo so the remainder follows the divisor's sign
        if ((m != 0) && ((m < 0) != (rr < 0))) begin
          m = m + rr;
        end
        res = q[WIDTH-1:0];
        rem = m[WIDTH-1:0];
      end
      default: begin
        res = '0;
      end
    endcase
    return {res, rem};
  endfunction

  function automatic logic model_busy(input int at_cycle);
    return (at_cycle >= div_start) && (at_cycle <= busy_to);
  endfunction

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s at cycle %0d: got 0x%h, expected 0x%h",
               name, cycle, actual, expected);
      abort_run();
    end
  endtask

  // Drives one go for a cycle and records what the DUT should answer
  task automatic issue_op(input op_t code, input logic [WIDTH-1:0] l,
                          input logic [WIDTH-1:0] r);
    logic [2*WIDTH-1:0] expected;
    logic               op_ok;
    int                 accept_cycle;
    op_ok = (code == OP_MUL) || (code == OP_DIVU) || (code == OP_DIVS);
    accept_cycle = cycle + 1;
    go    = 1'b1;
    op    = code;
    left  = l;
    right = r;
    if (op_ok && !model_busy(cycle)) begin
      expected = ref_result(code, l, r);
      exp_result_q.push_back(expected[2*WIDTH-1:WIDTH]);
      exp_rem_q.push_back(expected[WIDTH-1:0]);
      if (code == OP_MUL) begin
        exp_cycle_q.push_back(accept_cycle + MUL_LATENCY);
      end else begin
        exp_cycle_q.push_back(accept_cycle + DIV_LATENCY);
        div_start = accept_cycle;
        busy_to   = accept_cycle + DIV_LATENCY - 1;
      end
    end
    @(posedge clk);
    #1;
    go = 1'b0;
  endtask

  // Returns in the cycle where the next go is accepted again
  task automatic wait_idle();
    while (model_busy(cycle)) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Compare at the falling edge where all outputs have settled
  always @(negedge clk) begin
    logic             exp_done;
    logic             exp_busy;
    logic [WIDTH-1:0] exp_res;
    logic [WIDTH-1:0] exp_rem;
    if (!reset) begin
      if ((done === 1'b1) && (exp_cycle_q.size() == 0)) begin
        $display("done rose at cycle %0d with no operation outstanding", cycle);
        abort_run();
      end
      exp_done = (exp_cycle_q.size() != 0) && (exp_cycle_q[0] == cycle);
      exp_busy = model_busy(cycle);
      check_value("busy", 32'(busy), 32'(exp_busy));
      check_value("done", 32'(done), 32'(exp_done));
      if (exp_done) begin
        exp_res = exp_result_q.pop_front();
        exp_rem = exp_rem_q.pop_front();
        void'(exp_cycle_q.pop_front());
        check_value("result", 32'(result), 32'(exp_res));
        check_value("remainder", 32'(remainder), 32'(exp_rem));
      end
    end
  end

  // A failed timing assertion in the bound checker ends the run at once
  always @(DUT.u_assert.fail_count) begin
    if (DUT.u_assert.fail_count != 0) begin
      $display("A timing assertion failed at cycle %0d", cycle);
      abort_run();
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  initial begin
    int               i;
    int               shift;
    int               d;
    int               q;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [WIDTH-1:0] l;
    logic [WIDTH-1:0] r;
    clk       = 1'b0;
    reset     = 1'b1;
    go        = 1'b0;
    op        = OP_MUL;
    left      = '0;
    right     = '0;
    rng_state = SEED;
    div_start = 1;
    busy_to   = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;

    // One multiply per cycle
    for (i = 0; i < NUM_MUL; i++) begin
      a = next_random();
      b = next_random();
      issue_op(OP_MUL, a[WIDTH-1:0], b[WIDTH-1:0]);
    end

    // Unsigned divides with the divisor scaled down for varied quotients
    for (i = 0; i < NUM_DIVU; i++) begin
      a     = next_random();
      b     = next_random();
      shift = int'(next_random() % 14);
      r     = b[WIDTH-1:0] >> shift;
      if (r == '0) begin
        r = WIDTH'(1);
      end
      issue_op(OP_DIVU, a[WIDTH-1:0], r);
      wait_idle();
    end

    // Signed divides where the low two bits of i pick the sign combination
    for (i = 0; i < NUM_DIVS; i++) begin
      a = next_random();
      b = next_random();
      l = {1'b0, a[WIDTH-2:0]};
      r = i[2] ? {8'h00, b[7:0]} : {1'b0, b[WIDTH-2:0]};
      if (r == '0) begin
        r = WIDTH'(1);
      end
      if (i[0]) begin
        l = -l;
      end
      if (i[1]) begin
        r = -r;
      end
      issue_op(OP_DIVS, l, r);
      wait_idle();
    end

    // Exact multiples whose remainder must come back zero
    for (i = 0; i < NUM_EXACT; i++) begin
      d = int'(next_random() % 255) + 1;
      q = int'(next_random() % 128);
      l = WIDTH'(q * d);
      r = WIDTH'(d);
      if (i[0]) begin
        l = -l;
      end
      if (i[1]) begin
        r = -r;
      end
      issue_op(OP_DIVS, l, r);
      wait_idle();
    end

    // Requests during a divide are dropped
    issue_op(OP_DIVU, 16'd1000, 16'd7);
    issue_op(OP_MUL, 16'd3, 16'd5);
    issue_op(OP_DIVS, 16'hfff0, 16'd3);
    issue_op(OP_MUL, 16'h00ff, 16'h0101);
    wait_idle();

    // Reserved opcode
    issue_op(op_t'(2'd3), 16'd9, 16'd9);
    issue_op(op_t'(2'd3), 16'h8000, 16'h0001);
    issue_op(OP_MUL, 16'h1234, 16'h0003);

    // Divide by zero and zero dividends
    issue_op(OP_DIVU, 16'h1357, 16'h0000);
    wait_idle();
    issue_op(OP_DIVU, 16'hffff, 16'h0000);
    wait_idle();
    issue_op(OP_DIVU, 16'h0000, 16'h0023);
    wait_idle();
    issue_op(OP_DIVS, 16'h0000, 16'hffd0);
    wait_idle();

    // Most negative dividend
    issue_op(OP_DIVS, 16'h8000, 16'hffff);
    wait_idle();
    issue_op(OP_DIVS, 16'h8000, 16'h0007);

    // Multiply lands in the done cycle of the divide before it
    wait_idle();
    issue_op(OP_MUL, 16'hfffd, 16'h0101);

    while (exp_cycle_q.size() != 0) begin
      @(posedge clk);
    end
    // A few idle cycles to catch a stray done
    repeat (4) @(posedge clk);
    #1;

    if (DUT.u_assert.fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("%0d assertion failures", DUT.u_assert.fail_count);
      $display("Checks failed");
      $fatal(1);
    end
  end

endmodule

// File: compile.f
design/arith_pkg.sv
design/op_capture.sv
design/mult_pipe.sv
design/div_core.sv
design/result_format.sv
design/arith_unit.sv
tb/arith_unit_assert.sv
tb/arith_unit_tb.sv
